/* logic/cursor_geom_pkg.sv */
//////////////////////////////
// cursor geometry: field size, sprite art and the
// position and pixel types shared by motion and shade
//////////////////////////////
package cursor_geom_pkg;

	// raster field, both axes wrap at this size
	localparam int field_size = 128;
	localparam int coord_w    = $clog2(field_size); // 7 bits per coordinate

	typedef logic [coord_w-1:0] coord_t;

	// colour depth of one pixel
	localparam int rgb_w = 3;
	typedef logic [rgb_w-1:0] rgb_t;

	// cursor sprite is square
	localparam int sprite_size  = 4;
	localparam int sprite_sh    = $clog2(sprite_size); // bits of one sprite offset
	localparam int sprite_cells = sprite_size * sprite_size;

	typedef logic [2*sprite_sh-1:0] sprite_idx_t; // dy*4 + dx

	// motion tick every 2**tick_shift clocks
	localparam int tick_shift = 4;
	typedef logic [tick_shift-1:0] tick_cnt_t;

	// home position after reset, centre of the field
	localparam coord_t reset_x = coord_t'(64);
	localparam coord_t reset_y = coord_t'(64);

	// arrow sprite, row-major, entry 0 top-left
	// zero entries are transparent and show the background
	localparam rgb_t sprite_rom [0:sprite_cells-1] = '{
		3'd7, 3'd7, 3'd7, 3'd7, // row 0, arrow head
		3'd7, 3'd0, 3'd6, 3'd1, // row 1
		3'd7, 3'd6, 3'd0, 3'd1, // row 2
		3'd7, 3'd1, 3'd1, 3'd0  // row 3, tail
	};

	typedef struct packed {
		coord_t x;
		coord_t y;
	} cursor_pos_t; // 14 bits

	typedef struct packed {
		logic   valid; // scan pixel present this cycle
		coord_t x;
		coord_t y;
		rgb_t   rgb;
	} pixel_t; // 18 bits

endpackage

/* logic/cursor_cmd_pkg.sv */
//////////////////////////////
// host command words and the decoded request
//////////////////////////////
package cursor_cmd_pkg;

	// width of the move step count
	localparam int step_w = 4;
	typedef logic [step_w-1:0] step_t;

	typedef enum logic [1:0] {
		op_nop  = 2'd0,
		op_move = 2'd1,
		op_jump = 2'd2,
		op_show = 2'd3  // move layout, move_x is the visibility flag
	} op_e;

	// relative move, op sits in the top two bits of either view
	typedef struct packed {
		op_e        op;
		logic       plus;   // 1 counts up, 0 counts down
		logic       move_x; // step the x axis
		logic       move_y; // step the y axis
		step_t      step;   // number of one-pixel steps
		logic [6:0] pad;
	} move_word_t; // 16 bits

	// absolute position
	typedef struct packed {
		op_e                               op;
		logic [cursor_geom_pkg::coord_w-1:0] x;
		logic [cursor_geom_pkg::coord_w-1:0] y;
	} jump_word_t; // 16 bits

	typedef union packed {
		move_word_t mv;
		jump_word_t jmp;
	} cmd_word_u;

	// request handed from decode to motion
	typedef struct packed {
		op_e                          kind;
		logic                         plus;
		logic                         move_x; // also the show flag
		logic                         move_y;
		step_t                        step;
		cursor_geom_pkg::cursor_pos_t target; // jump destination
	} cmd_req_t;

endpackage

/* logic/cursor_cmd_decode.sv */
//////////////////////////////
// command decode, splits host words into
// registered move, jump and show requests
//////////////////////////////
`timescale 1ns/1ps

module cursor_cmd_decode (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     cmd_strobe, // one-cycle word valid
	input  cursor_cmd_pkg::cmd_word_u cmd,
	output logic                     req_strobe,
	output cursor_cmd_pkg::cmd_req_t  req
);

	cursor_cmd_pkg::cmd_req_t next_req;
	logic                     is_nop;

	// op read through the move view, same bits in the jump view
	assign is_nop = (cmd.mv.op == cursor_cmd_pkg::op_nop);

	always_comb begin
		next_req      = '0;
		next_req.kind = cmd.mv.op;
		if (cmd.mv.op == cursor_cmd_pkg::op_jump) begin
			// absolute target from the jump view
			next_req.target.x = cmd.jmp.x;
			next_req.target.y = cmd.jmp.y;
		end else begin
			// move and show share the move layout
			next_req.plus   = cmd.mv.plus;
			next_req.move_x = cmd.mv.move_x; // show flag for show words
			next_req.move_y = cmd.mv.move_y;
			next_req.step   = cmd.mv.step;
		end
	end

	// strobe one clock after the host strobe, nops swallowed here
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			req_strobe <= 1'b0;
		else
			req_strobe <= cmd_strobe && !is_nop;
	end

	// request payload only loads with a word
	always_ff @(posedge clk) begin
		if (cmd_strobe)
			req <= next_req;
	end

endmodule

/* logic/cursor_motion.sv */
//////////////////////////////
// cursor motion, slow tick stepping
// plus jump and visibility state
//////////////////////////////
`timescale 1ns/1ps

module cursor_motion (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         req_strobe,
	input  cursor_cmd_pkg::cmd_req_t     req,
	output cursor_geom_pkg::cursor_pos_t cursor,
	output logic                         visible,
	output logic                         busy     // move in progress
);

	cursor_geom_pkg::tick_cnt_t tick_cnt; // free running divider
	logic                       tick;
	logic                       accept;
	logic                       dir_plus; // latched at move start
	logic                       dir_x;
	logic                       dir_y;
	cursor_cmd_pkg::step_t      steps_left;

	// clock enable divider, counts from reset without stopping
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			tick_cnt <= '0;
		else
			tick_cnt <= tick_cnt + cursor_geom_pkg::tick_cnt_t'(1);
	end

	assign tick   = &tick_cnt;          // rollover cycle
	assign accept = req_strobe && !busy; // overrun: drop anything during a move

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			cursor.x   <= cursor_geom_pkg::reset_x;
			cursor.y   <= cursor_geom_pkg::reset_y;
			visible    <= 1'b1;
			busy       <= 1'b0;
			dir_plus   <= 1'b0;
			dir_x      <= 1'b0;
			dir_y      <= 1'b0;
			steps_left <= '0;
		end else if (accept) begin
			case (req.kind)
				cursor_cmd_pkg::op_move: begin
					dir_plus   <= req.plus;
					dir_x      <= req.move_x;
					dir_y      <= req.move_y;
					steps_left <= req.step;
					busy       <= (req.step != '0); // zero step stays idle
				end
				cursor_cmd_pkg::op_jump: cursor <= req.target;
				cursor_cmd_pkg::op_show: visible <= req.move_x;
				default: ; // nop never strobes
			endcase
		end else if (busy && tick) begin
			// one pixel per tick, 7-bit arithmetic wraps at 128
			if (dir_x)
				cursor.x <= dir_plus ? cursor.x + cursor_geom_pkg::coord_t'(1)
				                     : cursor.x - cursor_geom_pkg::coord_t'(1);
			if (dir_y)
				cursor.y <= dir_plus ? cursor.y + cursor_geom_pkg::coord_t'(1)
				                     : cursor.y - cursor_geom_pkg::coord_t'(1);
			steps_left <= steps_left - cursor_cmd_pkg::step_t'(1);
			// busy drops with the last step
			if (steps_left == cursor_cmd_pkg::step_t'(1))
				busy <= 1'b0;
		end
	end

endmodule

/* logic/cursor_pixel_shade.sv */
//////////////////////////////
// pixel shade, overlays the cursor sprite
// on scan pixels in two stages
//////////////////////////////
`timescale 1ns/1ps

module cursor_pixel_shade (
	input  logic                         clk,
	input  logic                         reset,
	input  cursor_geom_pkg::pixel_t      scan_in,
	input  cursor_geom_pkg::cursor_pos_t cursor,
	input  logic                         visible,
	output cursor_geom_pkg::pixel_t      pix_out
);

	cursor_geom_pkg::coord_t      dx;     // scan minus cursor, mod 128
	cursor_geom_pkg::coord_t      dy;
	logic                         hit;
	cursor_geom_pkg::sprite_idx_t idx;

	cursor_geom_pkg::pixel_t      s1_pix; // stage 1 background pixel
	logic                         s1_hit;
	cursor_geom_pkg::sprite_idx_t s1_idx;
	cursor_geom_pkg::rgb_t        rom_rgb;

	// offsets wrap naturally, so a box across the edge still hits
	assign dx = scan_in.x - cursor.x;
	assign dy = scan_in.y - cursor.y;

	// inside the box when the upper offset bits are clear
	assign hit = visible
	          && ~|dx[cursor_geom_pkg::coord_w-1:cursor_geom_pkg::sprite_sh]
	          && ~|dy[cursor_geom_pkg::coord_w-1:cursor_geom_pkg::sprite_sh];

	// row-major index dy*4 + dx
	assign idx = {dy[cursor_geom_pkg::sprite_sh-1:0], dx[cursor_geom_pkg::sprite_sh-1:0]};

	// stage 1, cursor sampled as the pixel enters
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			s1_pix <= '0;
			s1_hit <= 1'b0;
			s1_idx <= '0;
		end else begin
			s1_pix <= scan_in;
			s1_hit <= hit;
			s1_idx <= idx;
		end
	end

	assign rom_rgb = cursor_geom_pkg::sprite_rom[s1_idx];

	// stage 2, sprite colour unless miss or transparent cell
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pix_out <= '0;
		end else begin
			pix_out.valid <= s1_pix.valid;
			pix_out.x     <= s1_pix.x;     // coordinates pass through
			pix_out.y     <= s1_pix.y;
			pix_out.rgb   <= (s1_hit && rom_rgb != '0) ? rom_rgb : s1_pix.rgb;
		end
	end

endmodule

/* logic/cursor_overlay_top.sv */
//////////////////////////////
// cursor overlay top, decode to motion to shade
//////////////////////////////
`timescale 1ns/1ps

module cursor_overlay_top (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         cmd_strobe,
	input  cursor_cmd_pkg::cmd_word_u    cmd,
	input  cursor_geom_pkg::pixel_t      scan_in, // from the display side
	output cursor_geom_pkg::cursor_pos_t cursor,
	output logic                         busy,
	output cursor_geom_pkg::pixel_t      pix_out
);

	logic                     req_strobe;
	cursor_cmd_pkg::cmd_req_t req;
	logic                     visible; // show state, motion to shade

	cursor_cmd_decode u_decode (
		.clk        (clk),
		.reset      (reset),
		.cmd_strobe (cmd_strobe),
		.cmd        (cmd),
		.req_strobe (req_strobe),
		.req        (req)
	);

	cursor_motion u_motion (
		.clk        (clk),
		.reset      (reset),
		.req_strobe (req_strobe),
		.req        (req),
		.cursor     (cursor),
		.visible    (visible),
		.busy       (busy)
	);

	cursor_pixel_shade u_shade (
		.clk     (clk),
		.reset   (reset),
		.scan_in (scan_in),
		.cursor  (cursor),
		.visible (visible),
		.pix_out (pix_out)
	);

endmodule

/* tb/cursor_overlay_props.sv */
//////////////////////////////
// cursor overlay properties, bound to the top
//////////////////////////////
`timescale 1ns/1ps

module cursor_overlay_props (
	input logic                         clk,
	input logic                         reset,
	input logic                         req_strobe, // decode to motion
	input logic                         busy,
	input cursor_geom_pkg::cursor_pos_t cursor,
	input logic                         scan_valid,
	input logic                         pix_valid
);

	// idle with no request, position holds
	hold_when_idle: assert property (@(posedge clk) disable iff (reset)
		(!busy && !req_strobe) |=> $stable(cursor))
		else $error("cursor changed while idle with no request");

	// only an accepted request can start a move
	no_spurious_busy: assert property (@(posedge clk) disable iff (reset)
		(!busy && !req_strobe) |=> !busy)
		else $error("busy rose without a request");

	// shade is exactly two deep
	valid_two_late: assert property (@(posedge clk) disable iff (reset)
		pix_valid == $past(scan_valid, 2))
		else $error("pix_out valid is not scan_in valid two clocks back");

endmodule

bind cursor_overlay_top cursor_overlay_props props0 (
	.clk        (clk),
	.reset      (reset),
	.req_strobe (req_strobe),
	.busy       (busy),
	.cursor     (cursor),
	.scan_valid (scan_in.valid),
	.pix_valid  (pix_out.valid)
);

/* tb/cursor_overlay_tb.sv */
//////////////////////////////
// cursor overlay testbench, plays the vector
// file into the top and checks cursor and pixels
//////////////////////////////
`timescale 1ns/1ps

module cursor_overlay_tb;

	localparam int max_vec    = 64;
	localparam int busy_limit = 400; // 15 steps of 16 clocks plus slack
	localparam int pix_limit  = 8;

	// own copy of the arrow art in row-major order
	// zero cells are see-through
	localparam logic [2:0] arrow [0:15] = '{
		3'd7, 3'd7, 3'd7, 3'd7,
		3'd7, 3'd0, 3'd6, 3'd1,
		3'd7, 3'd6, 3'd0, 3'd1,
		3'd7, 3'd1, 3'd1, 3'd0
	};

	// one line of the vector file
	typedef struct packed {
		logic [3:0]                   kind; // 1 cmd, 2 move start, 3 cmd during move, 4 probe
		logic [15:0]                  data; // command word, or probe x in [14:8] and y in [6:0]
		cursor_geom_pkg::cursor_pos_t want; // cursor expected after the line
	} vec_t;

	logic                         clk;
	logic                         reset;
	logic                         cmd_strobe;
	cursor_cmd_pkg::cmd_word_u    cmd;
	cursor_geom_pkg::pixel_t      scan_in;
	cursor_geom_pkg::cursor_pos_t cursor;
	logic                         busy;
	cursor_geom_pkg::pixel_t      pix_out;

	logic [15:0] vec_mem [0:4*max_vec-1]; // four columns per line
	int          errors;
	int          checks;
	logic        abort;   // set on a timeout to stop playback
	logic        show_on; // visibility as the last show word left it

	cursor_overlay_top dut0 (
		.clk        (clk),
		.reset      (reset),
		.cmd_strobe (cmd_strobe),
		.cmd        (cmd),
		.scan_in    (scan_in),
		.cursor     (cursor),
		.busy       (busy),
		.pix_out    (pix_out)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// non-zero art inside the 4x4 box beats the background, offsets mod 128
	function automatic logic [2:0] expect_rgb(input cursor_geom_pkg::cursor_pos_t at,
			input logic [6:0] px, input logic [6:0] py, input logic [2:0] bg, input logic vis);
		logic [6:0] dx;
		logic [6:0] dy;
		logic [2:0] art;
		dx = px - at.x; // 7-bit wrap
		dy = py - at.y;
		if (!vis || dx >= 7'd4 || dy >= 7'd4)
			return bg;
		art = arrow[4 * int'(dy) + int'(dx)];
		return (art == 3'd0) ? bg : art;
	endfunction

	task automatic wait_cycles(input int n);
		for (int i = 0; i < n; i++)
			@(negedge clk);
	endtask

	task automatic check_value(input string name, input int want, input int got);
		checks++;
		assert (want == got) else begin
			errors++;
			$display("Fail %s expected %0d actual %0d", name, want, got);
		end
	endtask

	// one-cycle strobe driven between two falling edges
	task automatic send_word(input logic [15:0] word);
		cmd_strobe = 1'b1;
		cmd        = word;
		wait_cycles(1);
		cmd_strobe = 1'b0;
	endtask

	task automatic wait_idle(input string name);
		int n;
		n = 0;
		while (busy && n < busy_limit) begin
			@(negedge clk);
			n++;
		end
		assert (!busy) else begin
			errors++;
			abort = 1'b1;
			$display("timeout in %s, busy still high after %0d cycles", name, busy_limit);
		end
	endtask

	task automatic check_pos(input string name, input cursor_geom_pkg::cursor_pos_t want);
		check_value({name, " x"}, int'(want.x), int'(cursor.x));
		check_value({name, " y"}, int'(want.y), int'(cursor.y));
	endtask

	// runs any command and waits it out by its own rule
	task automatic run_command(input string name, input logic [15:0] word,
			input cursor_geom_pkg::cursor_pos_t want);
		cursor_cmd_pkg::op_e op;
		op = cursor_cmd_pkg::op_e'(word[15:14]);
		send_word(word);
		wait_cycles(2); // decode plus motion register
		if (op == cursor_cmd_pkg::op_move) begin
			check_value({name, " busy"}, int'(word[10:7] != 4'd0), int'(busy));
			wait_idle(name);
		end
		if (op == cursor_cmd_pkg::op_show)
			show_on = word[12];
		check_pos(name, want);
	endtask

	// move left running so the next line lands inside it
	task automatic start_move(input string name, input logic [15:0] word);
		send_word(word);
		wait_cycles(2);
		check_value({name, " busy"}, 1, int'(busy));
	endtask

	// overrun drops the word and the move carries on
	task automatic command_in_move(input string name, input logic [15:0] word,
			input cursor_geom_pkg::cursor_pos_t want);
		send_word(word);
		wait_cycles(2);
		check_value({name, " busy"}, 1, int'(busy));
		wait_idle(name);
		check_pos(name, want);
	endtask

	task automatic probe_pixel(input string name, input logic [6:0] px, input logic [6:0] py,
			input cursor_geom_pkg::cursor_pos_t want);
		logic [2:0] bg;
		int         lat;
		// background never matches what the sprite would show here
		do
			bg = 3'($urandom());
		while (bg == expect_rgb(want, px, py, 3'd0, 1'b1));
		scan_in = '{valid: 1'b1, x: px, y: py, rgb: bg};
		wait_cycles(1);
		scan_in.valid = 1'b0;
		lat = 1;
		while (!pix_out.valid && lat < pix_limit) begin
			@(negedge clk);
			lat++;
		end
		assert (pix_out.valid) else begin
			errors++;
			abort = 1'b1;
			$display("timeout in %s, no valid pixel came out", name);
		end
		check_value({name, " latency"}, 2, lat);
		check_value({name, " pix x"}, int'(px), int'(pix_out.x));
		check_value({name, " pix y"}, int'(py), int'(pix_out.y));
		check_value({name, " rgb"}, int'(expect_rgb(want, px, py, bg, show_on)),
			int'(pix_out.rgb));
		check_pos(name, want);
	endtask

	initial begin
		vec_t  v;
		string name;
		int    n;
		errors     = 0;
		checks     = 0;
		abort      = 1'b0;
		show_on    = 1'b1; // visible out of reset
		reset      = 1'b1;
		cmd_strobe = 1'b0;
		cmd        = '0;
		scan_in    = '0;
		void'($urandom(42));
		$readmemh("tb/cursor_vectors.txt", vec_mem);
		wait_cycles(16);
		reset = 1'b0;
		wait_cycles(1);

		// home position and idle
		check_value("reset x", 64, int'(cursor.x));
		check_value("reset y", 64, int'(cursor.y));
		check_value("reset busy", 0, int'(busy));
		check_value("reset pix valid", 0, int'(pix_out.valid));

		n = 0;
		while (!abort && n < max_vec) begin
			v = {vec_mem[4*n][3:0], vec_mem[4*n+1], vec_mem[4*n+2][6:0], vec_mem[4*n+3][6:0]};
			if (v.kind == 4'hf)
				break;
			name = $sformatf("vector %0d", n);
			case (v.kind)
				4'h1: run_command(name, v.data, v.want);
				4'h2: start_move(name, v.data);
				4'h3: command_in_move(name, v.data, v.want);
				4'h4: probe_pixel(name, v.data[14:8], v.data[6:0], v.want);
				default: begin
					errors++;
					abort = 1'b1;
					$display("vector %0d has an unknown kind %0h", n, v.kind);
				end
			endcase
			n++;
		end

		$display("vectors %0d checks %0d errors %0d", n, checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* tb/cursor_vectors.txt */
// kind data want_x want_y, all hex; kind 1 cmd, 2 move start, 3 cmd during move, 4 probe, f end
// probe data is x in the high byte and y in the low byte, want is the cursor at that time
1 0000 40 40 // nop, nothing moves
1 8101 02 01 // jump to 2,1
1 5280 7d 01 // x down 5, wraps past 0
1 7a00 01 05 // both up 4, x wraps past 127
1 7000 01 05 // step 0, busy stays low
1 4b80 01 7e // y down 7 only
1 9030 20 30 // jump to 20,30
4 2030 20 30
4 2130 20 30
4 2230 20 30
4 2330 20 30
4 2031 20 30
4 2131 20 30 // transparent cell
4 2231 20 30
4 2331 20 30
4 2032 20 30
4 2132 20 30
4 2232 20 30
4 2332 20 30
4 2033 20 30
4 2133 20 30
4 2233 20 30
4 2333 20 30
4 2430 20 30 // one right of the box
4 1f33 20 30 // one left of the box
1 c000 20 30 // hide
4 2030 20 30
4 2231 20 30
1 d000 20 30 // show again
4 2030 20 30
1 bf7f 7e 7f // jump near the corner
4 0000 7e 7f // box crosses the wrap edge
4 017f 7e 7f
4 7e00 7e 7f
2 7180 7e 7f // x up 3, left running
3 8000 01 7f // jump during the move is dropped
4 027f 01 7f
f 0000 00 00

/* tb.f */
logic/cursor_geom_pkg.sv
logic/cursor_cmd_pkg.sv
logic/cursor_cmd_decode.sv
logic/cursor_motion.sv
logic/cursor_pixel_shade.sv
logic/cursor_overlay_top.sv
tb/cursor_overlay_props.sv
tb/cursor_overlay_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := cursor_overlay_tb
FILELIST   := tb.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -j 0
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_TEXT  := ALL TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
